// File: src/udp_defs.svh
// ##########################################################################
// UDP receive widths and sizes
// Beat, byte-enable, port and address widths shared by the package and RTL
// ##########################################################################

`ifndef UDP_DEFS_SVH
`define UDP_DEFS_SVH

// Payload beat and its byte enables
`define UDP_DATA_W    64
`define UDP_KEEP_W    8

// UDP header is a single 8-byte beat
`define UDP_HDR_BYTES 8

// Port, length and checksum fields
`define UDP_PORT_W    16
`define IP_ADDR_W     32

`endif

// File: src/udp_pkg.sv
// ##########################################################################
// UDP receive package
// FSM state encoding and the field types of the receive datapath
// ##########################################################################

`default_nettype none

`include "udp_defs.svh"

package udp_pkg;

  // Frame sequencing states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_HEADER  = 2'd1,
    ST_PAYLOAD = 2'd2
  } rx_state_t;

  typedef logic [`UDP_DATA_W-1:0] beat_t;
  typedef logic [`UDP_KEEP_W-1:0] keep_t;

  // Port, length or checksum
  typedef logic [`UDP_PORT_W-1:0] port_t;

  typedef logic [`IP_ADDR_W-1:0] ip_addr_t;

endpackage

`default_nettype wire

// File: src/udp_rx_ctrl.sv
// ##########################################################################
// UDP receive controller
// Sequences IP header, UDP header beat and payload, drives all readies and
// load strobes, and raises busy and the early termination pulses
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module udp_rx_ctrl
  import udp_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic s_ip_hdr_valid,
  input  logic s_payload_tvalid,
  input  logic s_payload_tlast,
  input  logic hdr_out_busy,
  input  logic pipe_ready,
  input  logic short_beat,
  output logic s_ip_hdr_ready,
  output logic s_payload_tready,
  output logic ip_hdr_load,
  output logic hdr_load,
  output logic len_load,
  output logic pipe_load,
  output logic load_any,
  output logic mark_error,
  output logic busy,
  output logic error_header_early_termination,
  output logic error_payload_early_termination
);

  rx_state_t state;
  rx_state_t state_next;
  logic      hdr_accept;

  // New IP header only once the previous UDP header has been taken
  assign s_ip_hdr_ready = (state == ST_IDLE) && !hdr_out_busy;
  assign ip_hdr_load    = s_ip_hdr_valid && s_ip_hdr_ready;

  assign s_payload_tready = (state == ST_HEADER)  ? !hdr_out_busy :
                            (state == ST_PAYLOAD) ? pipe_ready : 1'b0;

  // Header beat taken with or without tlast
  assign hdr_accept = (state == ST_HEADER) && s_payload_tvalid && !hdr_out_busy;
  assign hdr_load   = hdr_accept && !s_payload_tlast;
  assign len_load   = hdr_accept;

  assign pipe_load = (state == ST_PAYLOAD) && s_payload_tvalid && pipe_ready;
  assign load_any  = pipe_load || hdr_load;

  // Last beat arrives with bytes still owed by the UDP length
  assign mark_error = (state == ST_PAYLOAD) && s_payload_tlast && short_beat;

  assign busy = (state != ST_IDLE);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (ip_hdr_load) begin
          state_next = ST_HEADER;
        end
      end
      ST_HEADER: begin
        if (hdr_accept) begin
          state_next = s_payload_tlast ? ST_IDLE : ST_PAYLOAD;
        end
      end
      ST_PAYLOAD: begin
        if (pipe_load && s_payload_tlast) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state                           <= ST_IDLE;
      error_header_early_termination  <= 1'b0;
      error_payload_early_termination <= 1'b0;
    end else begin
      state                           <= state_next;
      error_header_early_termination  <= hdr_accept && s_payload_tlast;
      error_payload_early_termination <= pipe_load && mark_error;
    end
  end

  // Upstream holds a pending IP header until it is taken
  a_ip_hdr_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    s_ip_hdr_valid && !s_ip_hdr_ready |=> s_ip_hdr_valid
  );

  // Stalled payload beat keeps its valid and its frame end
  a_payload_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    s_payload_tvalid && !s_payload_tready |=> s_payload_tvalid && $stable(s_payload_tlast)
  );

endmodule

`default_nettype wire

// File: src/udp_hdr_parse.sv
// ##########################################################################
// UDP header parser
// Captures IP addresses and the UDP header beat, holds the header until it
// is taken, and flags frames aimed at the RoCE port
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module udp_hdr_parse
  import udp_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ip_hdr_load,
  input  logic     hdr_load,
  input  ip_addr_t s_ip_source_ip,
  input  ip_addr_t s_ip_dest_ip,
  input  beat_t    s_payload_tdata,
  input  port_t    roce_udp_port,
  input  logic     m_udp_hdr_ready,
  output logic     m_udp_hdr_valid,
  output port_t    m_udp_source_port,
  output port_t    m_udp_dest_port,
  output port_t    m_udp_length,
  output port_t    m_udp_checksum,
  output ip_addr_t m_udp_source_ip,
  output ip_addr_t m_udp_dest_ip,
  output logic     m_is_roce_packet,
  output port_t    udp_length
);

  port_t hdr_src_port;
  port_t hdr_dst_port;
  port_t hdr_length;
  port_t hdr_checksum;

  // Network order, lower byte index is the high byte
  assign hdr_src_port = {s_payload_tdata[7:0],   s_payload_tdata[15:8]};
  assign hdr_dst_port = {s_payload_tdata[23:16], s_payload_tdata[31:24]};
  assign hdr_length   = {s_payload_tdata[39:32], s_payload_tdata[47:40]};
  assign hdr_checksum = {s_payload_tdata[55:48], s_payload_tdata[63:56]};

  // Length counter loads in the same cycle as the header
  assign udp_length = hdr_length;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_udp_hdr_valid <= 1'b0;
    end else if (hdr_load) begin
      m_udp_hdr_valid <= 1'b1;
    end else if (m_udp_hdr_ready) begin
      m_udp_hdr_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ip_hdr_load) begin
      m_udp_source_ip <= s_ip_source_ip;
      m_udp_dest_ip   <= s_ip_dest_ip;
    end
    if (hdr_load) begin
      m_udp_source_port <= hdr_src_port;
      m_udp_dest_port   <= hdr_dst_port;
      m_udp_length      <= hdr_length;
      m_udp_checksum    <= hdr_checksum;
      m_is_roce_packet  <= (hdr_dst_port == roce_udp_port);
    end
  end

  a_hdr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_udp_hdr_valid && !m_udp_hdr_ready |=>
      m_udp_hdr_valid && $stable(m_udp_source_port) && $stable(m_udp_dest_port) &&
      $stable(m_udp_length) && $stable(m_udp_checksum) &&
      $stable(m_udp_source_ip) && $stable(m_udp_dest_ip) && $stable(m_is_roce_packet)
  );

endmodule

`default_nettype wire

// File: src/udp_len_check.sv
// ##########################################################################
// UDP length check
// Counts payload bytes still owed by the UDP length field
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "udp_defs.svh"

module udp_len_check
  import udp_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  len_load,
  input  port_t udp_length,
  input  keep_t s_payload_tkeep,
  input  logic  beat_accept,
  output logic  short_beat
);

  localparam int CNT_W = $clog2(`UDP_KEEP_W + 1);

  logic [CNT_W-1:0] beat_bytes;
  port_t            beat_bytes_ext;
  port_t            remaining;

  // Popcount of the byte enables
  always_comb begin
    beat_bytes = '0;
    for (int i = 0; i < `UDP_KEEP_W; i++) begin
      beat_bytes = beat_bytes + CNT_W'(s_payload_tkeep[i]);
    end
  end

  assign beat_bytes_ext = port_t'(beat_bytes);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remaining <= '0;
    end else if (len_load) begin
      // Header beat itself is not payload
      if (udp_length > port_t'(`UDP_HDR_BYTES)) begin
        remaining <= udp_length - port_t'(`UDP_HDR_BYTES);
      end else begin
        remaining <= '0;
      end
    end else if (beat_accept) begin
      remaining <= (remaining > beat_bytes_ext) ? remaining - beat_bytes_ext : '0;
    end
  end

  // More owed than this beat carries
  assign short_beat = (remaining > beat_bytes_ext);

endmodule

`default_nettype wire

// File: src/udp_payload_reg.sv
// ##########################################################################
// UDP payload register
// Single output stage, ready when empty or being drained
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module udp_payload_reg
  import udp_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  pipe_load,
  input  logic  mark_error,
  input  beat_t s_payload_tdata,
  input  keep_t s_payload_tkeep,
  input  logic  s_payload_tlast,
  input  logic  m_payload_tready,
  output logic  pipe_ready,
  output beat_t m_payload_tdata,
  output keep_t m_payload_tkeep,
  output logic  m_payload_tvalid,
  output logic  m_payload_tlast,
  output logic  m_payload_tuser
);

  // Full-rate when the consumer keeps up
  assign pipe_ready = !m_payload_tvalid || m_payload_tready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_payload_tvalid <= 1'b0;
    end else if (pipe_load) begin
      m_payload_tvalid <= 1'b1;
    end else if (m_payload_tready) begin
      m_payload_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pipe_load) begin
      m_payload_tdata <= s_payload_tdata;
      m_payload_tkeep <= s_payload_tkeep;
      m_payload_tlast <= s_payload_tlast;
      m_payload_tuser <= mark_error;
    end
  end

  a_out_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_payload_tvalid && !m_payload_tready |=>
      m_payload_tvalid && $stable(m_payload_tdata) && $stable(m_payload_tkeep) &&
      $stable(m_payload_tlast) && $stable(m_payload_tuser)
  );

endmodule

`default_nettype wire

// File: src/udp_rx_top.sv
// ##########################################################################
// UDP receive block, 64-bit datapath
// Splits the UDP header off an IP frame and forwards the payload
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module udp_rx_top
  import udp_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // IP frame in
  input  logic     s_ip_hdr_valid,
  output logic     s_ip_hdr_ready,
  input  ip_addr_t s_ip_source_ip,
  input  ip_addr_t s_ip_dest_ip,
  input  beat_t    s_payload_tdata,
  input  keep_t    s_payload_tkeep,
  input  logic     s_payload_tvalid,
  output logic     s_payload_tready,
  input  logic     s_payload_tlast,
  // UDP frame out
  output logic     m_udp_hdr_valid,
  input  logic     m_udp_hdr_ready,
  output port_t    m_udp_source_port,
  output port_t    m_udp_dest_port,
  output port_t    m_udp_length,
  output port_t    m_udp_checksum,
  output ip_addr_t m_udp_source_ip,
  output ip_addr_t m_udp_dest_ip,
  output logic     m_is_roce_packet,
  output beat_t    m_payload_tdata,
  output keep_t    m_payload_tkeep,
  output logic     m_payload_tvalid,
  input  logic     m_payload_tready,
  output logic     m_payload_tlast,
  output logic     m_payload_tuser,
  // Status and config
  output logic     busy,
  output logic     error_header_early_termination,
  output logic     error_payload_early_termination,
  input  port_t    roce_udp_port
);

  logic  ip_hdr_load;
  logic  hdr_load;
  logic  len_load;
  logic  pipe_load;
  logic  load_any;
  logic  mark_error;
  logic  pipe_ready;
  logic  short_beat;
  port_t udp_length;

  udp_rx_ctrl u_ctrl (
    .clk                             (clk),
    .rst_n                           (rst_n),
    .s_ip_hdr_valid                  (s_ip_hdr_valid),
    .s_payload_tvalid                (s_payload_tvalid),
    .s_payload_tlast                 (s_payload_tlast),
    .hdr_out_busy                    (m_udp_hdr_valid),
    .pipe_ready                      (pipe_ready),
    .short_beat                      (short_beat),
    .s_ip_hdr_ready                  (s_ip_hdr_ready),
    .s_payload_tready                (s_payload_tready),
    .ip_hdr_load                     (ip_hdr_load),
    .hdr_load                        (hdr_load),
    .len_load                        (len_load),
    .pipe_load                       (pipe_load),
    .load_any                        (load_any),
    .mark_error                      (mark_error),
    .busy                            (busy),
    .error_header_early_termination  (error_header_early_termination),
    .error_payload_early_termination (error_payload_early_termination)
  );

  udp_hdr_parse u_hdr (
    .clk               (clk),
    .rst_n             (rst_n),
    .ip_hdr_load       (ip_hdr_load),
    .hdr_load          (hdr_load),
    .s_ip_source_ip    (s_ip_source_ip),
    .s_ip_dest_ip      (s_ip_dest_ip),
    .s_payload_tdata   (s_payload_tdata),
    .roce_udp_port     (roce_udp_port),
    .m_udp_hdr_ready   (m_udp_hdr_ready),
    .m_udp_hdr_valid   (m_udp_hdr_valid),
    .m_udp_source_port (m_udp_source_port),
    .m_udp_dest_port   (m_udp_dest_port),
    .m_udp_length      (m_udp_length),
    .m_udp_checksum    (m_udp_checksum),
    .m_udp_source_ip   (m_udp_source_ip),
    .m_udp_dest_ip     (m_udp_dest_ip),
    .m_is_roce_packet  (m_is_roce_packet),
    .udp_length        (udp_length)
  );

  udp_len_check u_len (
    .clk             (clk),
    .rst_n           (rst_n),
    .len_load        (len_load),
    .udp_length      (udp_length),
    .s_payload_tkeep (s_payload_tkeep),
    .beat_accept     (load_any),
    .short_beat      (short_beat)
  );

  udp_payload_reg u_pipe (
    .clk              (clk),
    .rst_n            (rst_n),
    .pipe_load        (pipe_load),
    .mark_error       (mark_error),
    .s_payload_tdata  (s_payload_tdata),
    .s_payload_tkeep  (s_payload_tkeep),
    .s_payload_tlast  (s_payload_tlast),
    .m_payload_tready (m_payload_tready),
    .pipe_ready       (pipe_ready),
    .m_payload_tdata  (m_payload_tdata),
    .m_payload_tkeep  (m_payload_tkeep),
    .m_payload_tvalid (m_payload_tvalid),
    .m_payload_tlast  (m_payload_tlast),
    .m_payload_tuser  (m_payload_tuser)
  );

endmodule

`default_nettype wire

// File: verif/udp_rx_tb.sv
// ##########################################################################
// UDP receive block testbench
// Table of frames applied in a loop with random payload and back-pressure,
// header, payload, RoCE flag, busy and early termination checked per frame
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module udp_rx_tb
  import udp_pkg::*;
;

  localparam int NROWS    = 10;
  localparam int TIMEOUT  = 1000;
  localparam int ROCE     = 4791;

  logic     clk;
  logic     rst_n;
  logic     s_ip_hdr_valid;
  logic     s_ip_hdr_ready;
  ip_addr_t s_ip_source_ip;
  ip_addr_t s_ip_dest_ip;
  beat_t    s_payload_tdata;
  keep_t    s_payload_tkeep;
  logic     s_payload_tvalid;
  logic     s_payload_tready;
  logic     s_payload_tlast;
  logic     m_udp_hdr_valid;
  logic     m_udp_hdr_ready;
  port_t    m_udp_source_port;
  port_t    m_udp_dest_port;
  port_t    m_udp_length;
  port_t    m_udp_checksum;
  ip_addr_t m_udp_source_ip;
  ip_addr_t m_udp_dest_ip;
  logic     m_is_roce_packet;
  beat_t    m_payload_tdata;
  keep_t    m_payload_tkeep;
  logic     m_payload_tvalid;
  logic     m_payload_tready;
  logic     m_payload_tlast;
  logic     m_payload_tuser;
  logic     busy;
  logic     error_header_early_termination;
  logic     error_payload_early_termination;
  port_t    roce_udp_port;

  // Frame table, err is 0 none, 1 short payload, 2 header early end
  int row_src [NROWS];
  int row_dst [NROWS];
  int row_len [NROWS];
  int row_bytes [NROWS];
  int row_hlast [NROWS];
  int row_roce [NROWS];
  int row_err [NROWS];

  // Two generators, payload bytes and output back-pressure
  logic [31:0] lfsr [2];

  // {tuser, tlast, tkeep, tdata} of beats still owed by the DUT
  logic [73:0] exp_q [$];

  int       err_cnt;
  int       pass_cnt;
  int       hdr_cnt;
  int       herr_cnt;
  int       perr_cnt;
  logic     stuck;
  port_t    got_src_port;
  port_t    got_dst_port;
  port_t    got_len;
  port_t    got_cks;
  ip_addr_t got_sip;
  ip_addr_t got_dip;
  logic     got_roce;

  udp_rx_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] rand_bits(input int which, input int n);
    logic [31:0] r;
    logic        b;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      b = lfsr[which][0];
      lfsr[which] = lfsr[which] >> 1;
      if (b) lfsr[which] = lfsr[which] ^ 32'h8020_0003;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                 input logic [63:0] got);
    $display("Fail at %0t ns: %s expected 0x%0h got 0x%0h", $time, sig, exp, got);
    err_cnt++;
  endtask

  task automatic set_row(input int i, input int src, input int dst, input int len,
                         input int nbytes, input int hlast, input int roce, input int err);
    row_src[i]   = src;
    row_dst[i]   = dst;
    row_len[i]   = len;
    row_bytes[i] = nbytes;
    row_hlast[i] = hlast;
    row_roce[i]  = roce;
    row_err[i]   = err;
  endtask

  // Random output readies, 3 in 4 cycles on average
  always @(negedge clk) begin
    m_payload_tready = (rand_bits(1, 2) != 0);
    m_udp_hdr_ready  = (rand_bits(1, 2) != 0);
  end

  // Output side scoreboard and pulse counters
  always @(posedge clk) begin
    if (rst_n) begin
      if (m_payload_tvalid && m_payload_tready) begin
        if (exp_q.size() == 0) begin
          $display("Output beat at %0t ns with no beat sent for it", $time);
          err_cnt++;
        end else begin
          if (m_payload_tdata !== exp_q[0][63:0])
            report_mismatch("m_payload_tdata", exp_q[0][63:0], m_payload_tdata);
          if (m_payload_tkeep !== exp_q[0][71:64])
            report_mismatch("m_payload_tkeep", exp_q[0][71:64], m_payload_tkeep);
          if (m_payload_tlast !== exp_q[0][72])
            report_mismatch("m_payload_tlast", exp_q[0][72], m_payload_tlast);
          if (m_payload_tuser !== exp_q[0][73])
            report_mismatch("m_payload_tuser", exp_q[0][73], m_payload_tuser);
          exp_q.delete(0);
        end
      end
      if (m_udp_hdr_valid && m_udp_hdr_ready) begin
        got_src_port = m_udp_source_port;
        got_dst_port = m_udp_dest_port;
        got_len      = m_udp_length;
        got_cks      = m_udp_checksum;
        got_sip      = m_udp_source_ip;
        got_dip      = m_udp_dest_ip;
        got_roce     = m_is_roce_packet;
        hdr_cnt++;
      end
      if (error_header_early_termination) herr_cnt++;
      if (error_payload_early_termination) perr_cnt++;
    end
  end

  task automatic send_ip_hdr(input ip_addr_t sip, input ip_addr_t dip);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    s_ip_source_ip = sip;
    s_ip_dest_ip   = dip;
    s_ip_hdr_valid = 1'b1;
    while (!taken && waited < TIMEOUT) begin
      @(posedge clk);
      taken = s_ip_hdr_ready;
      waited++;
      @(negedge clk);
    end
    s_ip_hdr_valid = 1'b0;
    if (!taken) begin
      $display("Timeout at %0t ns: IP header was never accepted", $time);
      err_cnt++;
      stuck = 1'b1;
    end
  endtask

  task automatic send_beat(input beat_t data, input keep_t keep, input logic last);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    s_payload_tdata  = data;
    s_payload_tkeep  = keep;
    s_payload_tlast  = last;
    s_payload_tvalid = 1'b1;
    while (!taken && waited < TIMEOUT) begin
      @(posedge clk);
      taken = s_payload_tready;
      waited++;
      @(negedge clk);
    end
    s_payload_tvalid = 1'b0;
    if (!taken) begin
      $display("Timeout at %0t ns: payload beat was never accepted", $time);
      err_cnt++;
      stuck = 1'b1;
    end
  endtask

  // Header taken, all beats out, FSM back in idle
  task automatic wait_drained();
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < TIMEOUT) begin
      @(negedge clk);
      done = (exp_q.size() == 0) && !m_payload_tvalid && !m_udp_hdr_valid && !busy;
      waited++;
    end
    if (!done) begin
      $display("Timeout at %0t ns: DUT did not drain the frame", $time);
      err_cnt++;
      stuck = 1'b1;
    end
  endtask

  task automatic run_frame(input int idx);
    ip_addr_t    sip;
    ip_addr_t    dip;
    port_t       src;
    port_t       dst;
    port_t       len;
    port_t       cks;
    beat_t       beat;
    keep_t       keep;
    logic        last;
    logic        short;
    logic [31:0] tmp;
    int          left;
    int          k;
    int          hdr_before;
    int          herr_before;
    int          perr_before;
    int          err_before;
    err_before  = err_cnt;
    hdr_before  = hdr_cnt;
    herr_before = herr_cnt;
    perr_before = perr_cnt;
    sip   = rand_bits(0, 32);
    dip   = rand_bits(0, 32);
    cks   = port_t'(rand_bits(0, 16));
    src   = port_t'(row_src[idx]);
    dst   = port_t'(row_dst[idx]);
    len   = port_t'(row_len[idx]);
    short = (row_err[idx] == 1);
    send_ip_hdr(sip, dip);
    if (busy !== 1'b1) report_mismatch("busy", 1'b1, busy);
    // Byte 0 is the high byte of the source port
    beat = {cks[7:0], cks[15:8], len[7:0], len[15:8], dst[7:0], dst[15:8], src[7:0], src[15:8]};
    send_beat(beat, 8'hff, row_hlast[idx] != 0);
    if (row_hlast[idx] != 0 && busy !== 1'b0) report_mismatch("busy", 1'b0, busy);
    left = (row_hlast[idx] != 0) ? 0 : row_bytes[idx];
    while (left > 0 && !stuck) begin
      beat = '0;
      keep = '0;
      for (k = 0; k < 8; k++) begin
        if (k < left) begin
          tmp = rand_bits(0, 8);
          beat[k*8 +: 8] = tmp[7:0];
          keep[k] = 1'b1;
        end
      end
      last = (left <= 8);
      exp_q.push_back({last && short, last, keep, beat});
      send_beat(beat, keep, last);
      if (busy !== !last) report_mismatch("busy", !last, busy);
      left = last ? 0 : left - 8;
    end
    wait_drained();
    if (row_hlast[idx] != 0) begin
      if (hdr_cnt != hdr_before) report_mismatch("m_udp_hdr_valid count", hdr_before, hdr_cnt);
    end else if (hdr_cnt != hdr_before + 1) begin
      report_mismatch("m_udp_hdr_valid count", hdr_before + 1, hdr_cnt);
    end else begin
      if (got_src_port !== src) report_mismatch("m_udp_source_port", src, got_src_port);
      if (got_dst_port !== dst) report_mismatch("m_udp_dest_port", dst, got_dst_port);
      if (got_len !== len) report_mismatch("m_udp_length", len, got_len);
      if (got_cks !== cks) report_mismatch("m_udp_checksum", cks, got_cks);
      if (got_sip !== sip) report_mismatch("m_udp_source_ip", sip, got_sip);
      if (got_dip !== dip) report_mismatch("m_udp_dest_ip", dip, got_dip);
      if (got_roce !== (row_roce[idx] != 0))
        report_mismatch("m_is_roce_packet", row_roce[idx], got_roce);
    end
    if (herr_cnt - herr_before != int'(row_err[idx] == 2))
      report_mismatch("error_header_early_termination pulses", row_err[idx] == 2,
                      herr_cnt - herr_before);
    if (perr_cnt - perr_before != int'(short))
      report_mismatch("error_payload_early_termination pulses", short,
                      perr_cnt - perr_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("test %0d dst %0d len %0d bytes %0d: ok", idx, dst, len, row_bytes[idx]);
    end else begin
      $display("test %0d dst %0d len %0d bytes %0d: %0d errors", idx, dst, len,
               row_bytes[idx], err_cnt - err_before);
    end
  endtask

  initial begin
    int i;
    lfsr[0] = 32'h9c00;
    lfsr[1] = 32'h9c00;
    err_cnt = 0;
    pass_cnt = 0;
    hdr_cnt = 0;
    herr_cnt = 0;
    perr_cnt = 0;
    stuck = 1'b0;
    rst_n = 1'b0;
    s_ip_hdr_valid = 1'b0;
    s_ip_source_ip = '0;
    s_ip_dest_ip = '0;
    s_payload_tdata = '0;
    s_payload_tkeep = '0;
    s_payload_tvalid = 1'b0;
    s_payload_tlast = 1'b0;
    m_udp_hdr_ready = 1'b0;
    m_payload_tready = 1'b0;
    roce_udp_port = port_t'(ROCE);
    //      src    dst   len  bytes hlast roce err
    set_row(0, 1234,  4791, 32,  24,  0,  1,  0);
    set_row(1, 5000,  53,   21,  13,  0,  0,  0);
    set_row(2, 4791,  80,   40,  20,  0,  0,  1);
    set_row(3, 7,     4791, 30,  10,  0,  1,  1);
    set_row(4, 1000,  2000, 16,  0,   1,  0,  2);
    set_row(5, 4790,  4792, 72,  64,  0,  0,  0);
    set_row(6, 60000, 4791, 9,   1,   0,  1,  0);
    set_row(7, 33,    44,   12,  30,  0,  0,  0);
    set_row(8, 4791,  4791, 100, 5,   0,  1,  1);
    set_row(9, 1,     4791, 20,  0,   1,  0,  2);
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    if (busy !== 1'b0) report_mismatch("busy", 1'b0, busy);
    if (m_udp_hdr_valid !== 1'b0) report_mismatch("m_udp_hdr_valid", 1'b0, m_udp_hdr_valid);
    if (m_payload_tvalid !== 1'b0) report_mismatch("m_payload_tvalid", 1'b0, m_payload_tvalid);
    if (error_header_early_termination !== 1'b0)
      report_mismatch("error_header_early_termination", 1'b0, error_header_early_termination);
    if (error_payload_early_termination !== 1'b0)
      report_mismatch("error_payload_early_termination", 1'b0, error_payload_early_termination);
    if (s_ip_hdr_ready !== 1'b1) report_mismatch("s_ip_hdr_ready", 1'b1, s_ip_hdr_ready);
    for (i = 0; i < NROWS && !stuck; i++) begin
      run_frame(i);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", NROWS, pass_cnt,
             NROWS - pass_cnt, err_cnt);
    if (err_cnt == 0 && pass_cnt == NROWS) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/udp_pkg.sv
src/udp_rx_ctrl.sv
src/udp_hdr_parse.sv
src/udp_len_check.sv
src/udp_payload_reg.sv
src/udp_rx_top.sv
verif/udp_rx_tb.sv
